/* all.f */
source/cache_pkg.sv
source/cache_mem_if.sv
source/axi4lite_controller.sv
source/cache_storage.sv
source/cache_controller.sv
source/cache_subsystem.sv
verification/axi4lite_memory_model.sv
verification/cache_subsystem_tb.sv

/* verification/cache_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem_tb;
    import cache_pkg::*;

    localparam int num_directed  = 8;
    localparam int num_random    = 300;
    localparam int timeout_limit = (num_directed + num_random) * 200 + 100;

    logic        clk;
    logic        reset;
    logic        cpu_req;
    logic        cpu_we;
    addr_t       cpu_addr;
    data_t       cpu_wdata;
    logic        cpu_done;
    data_t       cpu_rdata;
    addr_t       araddr;
    addr_t       awaddr;
    data_t       wdata;
    data_t       rdata;
    logic        arready;
    logic        rvalid;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic        arvalid;
    logic        rready;
    logic        awvalid;
    logic        wvalid;
    logic        bready;
    logic [1:0]  resp_delay = 2'd0;
    int          read_count;
    int          write_count;

    logic [31:0] lcg_state   = 32'd6;
    int          error_count = 0;
    int          done_count  = 0;
    int          cycle_count = 0;
    data_t       shadow [addr_t];                                        // Last written words.
    logic        exp_read_q [$];
    data_t       exp_data_q [$];

    cache_subsystem i_cache_subsystem
    (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_done  (cpu_done),
        .cpu_rdata (cpu_rdata),
        .araddr    (araddr),
        .awaddr    (awaddr),
        .wdata     (wdata),
        .rdata     (rdata),
        .arready   (arready),
        .rvalid    (rvalid),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .arvalid   (arvalid),
        .rready    (rready),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .bready    (bready)
    );

    axi4lite_memory_model i_axi4lite_memory_model
    (
        .clk         (clk),
        .reset       (reset),
        .resp_delay  (resp_delay),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .read_count  (read_count),
        .write_count (write_count)
    );

    initial
        clk = 1'b0;

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t fill_pattern(input addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F0F;
    endfunction

    function automatic data_t reference_word(input addr_t addr);
        if (shadow.exists(addr))
            return shadow[addr];
        return fill_pattern(addr);
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Called one step after a rising edge with the controller idle.
    task automatic access(input logic we, input addr_t addr, input data_t data,
                          output int cycles);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= data;
        exp_read_q.push_back(!we);
        exp_data_q.push_back(reference_word(addr));
        if (we)
            shadow[addr] = data;
        @(posedge clk);
        #1;
        cpu_req <= 1'b0;
        cycles = 1;
        while (!cpu_done)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        @(posedge clk);                                                  // Back to idle.
        #1;
    endtask

    task automatic access_and_count(input string what, input logic we, input addr_t addr,
                                    input data_t data, input int exp_reads,
                                    input int exp_writes, output int cycles);
        int reads_before;
        int writes_before;

        reads_before  = read_count;
        writes_before = write_count;
        access(we, addr, data, cycles);
        check_value({what, ", read transfers"}, read_count - reads_before, exp_reads);
        check_value({what, ", write transfers"}, write_count - writes_before, exp_writes);
    endtask

    always @(negedge clk)
    begin
        logic [31:0] rnd;

        rnd = next_random();
        resp_delay <= rnd[31:30];                                        // Memory stall of 0 to 3.
    end

    always @(negedge clk)
    begin
        if (reset && cpu_done)
        begin
            done_count++;
            if (exp_read_q.size() == 0)
            begin
                error_count++;
                $display("cpu_done at %0t with no request open", $time);
            end
            else if (exp_read_q.pop_front())
                check_value("read data", cpu_rdata, exp_data_q.pop_front());
            else
                void'(exp_data_q.pop_front());
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_limit)
        begin
            $display("Timeout after %0d cycles, cache controller in state %s",
                     cycle_count, i_cache_subsystem.i_cache_controller.state.name());
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        int          cycles;
        logic [31:0] rnd;
        addr_t       addr;
        data_t       value;

        reset     = 1'b0;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b1;
        check_value("outputs after reset", {cpu_done, arvalid, rready, awvalid, wvalid, bready},
                    32'd0);

        // Line 0 with tags 1, 5 and 9.
        access_and_count("read miss", 1'b0, 32'h040, '0, 1, 0, cycles);
        access_and_count("read hit", 1'b0, 32'h040, '0, 0, 0, cycles);
        check_value("read hit latency", cycles, 1);
        access_and_count("write hit", 1'b1, 32'h040, 32'h1234_ABCD, 0, 0, cycles);
        check_value("write hit latency", cycles, 1);
        access_and_count("read after write hit", 1'b0, 32'h040, '0, 0, 0, cycles);
        access_and_count("dirty eviction", 1'b0, 32'h140, '0, 1, 1, cycles);
        check_value("written back word", i_axi4lite_memory_model.mem_words[8'h10],
                    32'h1234_ABCD);
        access_and_count("re-read of evicted address", 1'b0, 32'h040, '0, 1, 0, cycles);
        access_and_count("write miss to clean line", 1'b1, 32'h240, 32'h0BAD_F00D, 0, 0, cycles);
        access_and_count("read after write miss", 1'b0, 32'h240, '0, 0, 0, cycles);
        check_value("hit latency after write miss", cycles, 1);

        for (int i = 0; i < num_random; i++)
        begin
            rnd   = next_random();
            addr  = {23'd0, rnd[24:18], 2'b00};                         // 8 tags on each line.
            value = next_random();
            access(rnd[31], addr, value, cycles);
        end

        check_value("completed accesses", done_count, num_directed + num_random);
        $display("Finished %0d accesses in %0d cycles with %0d errors",
                 done_count, cycle_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/axi4lite_memory_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi4lite_memory_model
(
    input  logic             clk,
    input  logic             reset,
    input  logic [1:0]       resp_delay,
    input  cache_pkg::addr_t araddr,
    input  logic             arvalid,
    output logic             arready,
    output cache_pkg::data_t rdata,
    output logic             rvalid,
    input  logic             rready,
    input  cache_pkg::addr_t awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  cache_pkg::data_t wdata,
    input  logic             wvalid,
    output logic             wready,
    output logic             bvalid,
    input  logic             bready,
    output int               read_count,
    output int               write_count
);
    import cache_pkg::*;

    data_t      mem_words [256];                                        // Byte addresses 0 to 0x3FF.
    logic       active;
    logic       read_open;                                               // Address taken, data pending.
    logic       write_open;
    logic [1:0] delay_q;
    logic [1:0] delay;
    logic [1:0] ready_at;
    logic [1:0] wait_count;
    logic       addr_ready;
    logic       read_busy;
    logic       write_busy;
    logic       respond;

    function automatic data_t fill_pattern(input addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F0F;
    endfunction

    initial
    begin
        for (int i = 0; i < 256; i++)
            mem_words[i] = fill_pattern(addr_t'(i) << 2);
    end

    // The first cycle of a transfer takes its delay straight from the generator.
    assign delay      = active ? delay_q : resp_delay;
    assign ready_at   = delay[0] ? {1'b0, delay[1]} : delay;           // Never after the response.
    assign addr_ready = (wait_count >= ready_at);
    assign read_busy  = arvalid || read_open;
    assign write_busy = awvalid || write_open;
    assign respond    = ((read_busy && rready) || (write_busy && bready))
                        && (wait_count == delay);

    assign arready = arvalid && addr_ready;
    assign awready = awvalid && wvalid && addr_ready;
    assign wready  = awready;
    assign rvalid  = read_busy && respond;
    assign bvalid  = write_busy && respond;
    assign rdata   = mem_words[araddr[9:2]];

    always @(posedge clk)
    begin
        if (awvalid && awready && wvalid && wready)
            mem_words[awaddr[9:2]] <= wdata;
    end

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            active      <= 1'b0;
            read_open   <= 1'b0;
            write_open  <= 1'b0;
            delay_q     <= 2'd0;
            wait_count  <= 2'd0;
            read_count  <= 0;
            write_count <= 0;
        end
        else
        begin
            if (arvalid && arready)
                read_count <= read_count + 1;
            if (awvalid && awready)
                write_count <= write_count + 1;
            if (respond || !(read_busy || write_busy))
            begin
                active     <= 1'b0;
                read_open  <= 1'b0;
                write_open <= 1'b0;
                wait_count <= 2'd0;
            end
            else
            begin
                active     <= 1'b1;
                wait_count <= wait_count + 2'd1;
                if (!active)
                    delay_q <= resp_delay;                               // Held for the transfer.
                if (arvalid && arready)
                    read_open <= 1'b1;
                if (awvalid && awready)
                    write_open <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cache_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem
(
    input  logic             clk,
    input  logic             reset,

    input  logic             cpu_req,
    input  logic             cpu_we,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::data_t cpu_wdata,
    output logic             cpu_done,
    output cache_pkg::data_t cpu_rdata,

    output cache_pkg::addr_t araddr,
    output cache_pkg::addr_t awaddr,
    output cache_pkg::data_t wdata,
    input  cache_pkg::data_t rdata,
    input  logic             arready,
    input  logic             rvalid,
    input  logic             awready,
    input  logic             wready,
    input  logic             bvalid,
    output logic             arvalid,
    output logic             rready,
    output logic             awvalid,
    output logic             wvalid,
    output logic             bready
);
    import cache_pkg::*;

    index_t lookup_index;
    logic   line_valid;
    logic   line_dirty;
    tag_t   line_tag;
    data_t  line_data;
    logic   update;
    tag_t   update_tag;
    data_t  update_data;
    logic   update_dirty;

    cache_mem_if mem_bus ();

    cache_controller i_cache_controller
    (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_done     (cpu_done),
        .cpu_rdata    (cpu_rdata),
        .mem          (mem_bus.requester),
        .lookup_index (lookup_index),
        .line_valid   (line_valid),
        .line_dirty   (line_dirty),
        .line_tag     (line_tag),
        .line_data    (line_data),
        .update       (update),
        .update_tag   (update_tag),
        .update_data  (update_data),
        .update_dirty (update_dirty)
    );

    cache_storage i_cache_storage
    (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (lookup_index),
        .line_valid   (line_valid),
        .line_dirty   (line_dirty),
        .line_tag     (line_tag),
        .line_data    (line_data),
        .update       (update),
        .update_tag   (update_tag),
        .update_data  (update_data),
        .update_dirty (update_dirty)
    );

    axi4lite_controller i_axi4lite_controller
    (
        .clk     (clk),
        .reset   (reset),
        .mem     (mem_bus.bus),
        .arready (arready),
        .rvalid  (rvalid),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .arvalid (arvalid),
        .rready  (rready),
        .awvalid (awvalid),
        .wvalid  (wvalid),
        .bready  (bready)
    );

    // One address serves both channels, only one transfer is open at a time.
    assign araddr            = mem_bus.mem_addr;
    assign awaddr            = mem_bus.mem_addr;
    assign wdata             = mem_bus.mem_wdata;
    assign mem_bus.mem_rdata = rdata;

endmodule

`default_nettype wire

/* source/cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_controller
(
    input  logic              clk,
    input  logic              reset,

    input  logic              cpu_req,
    input  logic              cpu_we,
    input  cache_pkg::addr_t  cpu_addr,
    input  cache_pkg::data_t  cpu_wdata,
    output logic              cpu_done,
    output cache_pkg::data_t  cpu_rdata,

    cache_mem_if.requester    mem,

    output cache_pkg::index_t lookup_index,
    input  logic              line_valid,
    input  logic              line_dirty,
    input  cache_pkg::tag_t   line_tag,
    input  cache_pkg::data_t  line_data,
    output logic              update,
    output cache_pkg::tag_t   update_tag,
    output cache_pkg::data_t  update_data,
    output logic              update_dirty
);
    import cache_pkg::*;

    cache_state_e state;
    logic         axi_valid_q;
    addr_t        req_addr;
    data_t        req_wdata;
    logic         req_we;
    tag_t         req_tag;
    index_t       req_index;
    logic         hit;
    logic         victim_dirty;
    logic         lookup_finish;
    addr_t        victim_addr;
    addr_t        refill_addr;

    assign req_tag   = req_addr[addr_width-1 -: tag_width];
    assign req_index = req_addr[offset_width +: index_width];

    assign hit           = line_valid && (line_tag == req_tag);
    assign victim_dirty  = line_valid && line_dirty && !hit;
    assign lookup_finish = hit || (req_we && !victim_dirty);           // Clean write miss allocates.

    assign victim_addr = {line_tag, req_index, {offset_width{1'b0}}};
    assign refill_addr = {req_tag, req_index, {offset_width{1'b0}}};

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            state       <= idle;
            axi_valid_q <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (cpu_req)
                        state <= lookup;
                end

                lookup:
                begin
                    if (lookup_finish)
                        state <= idle;
                    else if (victim_dirty)
                        state <= write_back;
                    else
                        state <= refill;
                end

                write_back, refill:
                begin
                    if (!axi_valid_q)
                    begin
                        axi_valid_q <= 1'b1;                             // Address settled one cycle earlier.
                    end
                    else if (mem.axi_ready)
                    begin
                        axi_valid_q <= 1'b0;
                        if (state == write_back && !req_we)
                            state <= refill;
                        else
                            state <= respond;
                    end
                end

                respond:
                begin
                    state <= idle;
                end

                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && cpu_req)
        begin
            req_addr  <= cpu_addr;
            req_we    <= cpu_we;
            req_wdata <= cpu_wdata;
        end
    end

    always_comb
    begin
        update       = 1'b0;
        update_tag   = req_tag;
        update_data  = req_wdata;
        update_dirty = 1'b1;

        case (state)
            lookup:
            begin
                if (lookup_finish && req_we)
                    update = 1'b1;
            end

            write_back:
            begin
                if (axi_valid_q && mem.axi_ready && req_we)
                    update = 1'b1;                                       // Write miss after eviction.
            end

            refill:
            begin
                if (axi_valid_q && mem.axi_ready)
                begin
                    update       = 1'b1;
                    update_data  = mem.mem_rdata;
                    update_dirty = 1'b0;
                end
            end

            default:
            begin
                update = 1'b0;
            end
        endcase
    end

    assign lookup_index = req_index;

    // Refilled word is already in the line during respond.
    assign cpu_done  = ((state == lookup) && lookup_finish) || (state == respond);
    assign cpu_rdata = line_data;

    assign mem.axi_valid  = axi_valid_q;
    assign mem.mem_wr_req = (state == write_back);
    assign mem.mem_addr   = (state == write_back) ? victim_addr : refill_addr;
    assign mem.mem_wdata  = line_data;                                  // Victim word.

endmodule

`default_nettype wire

/* source/cache_storage.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_storage
(
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::index_t lookup_index,
    output logic              line_valid,
    output logic              line_dirty,
    output cache_pkg::tag_t   line_tag,
    output cache_pkg::data_t  line_data,
    input  logic              update,
    input  cache_pkg::tag_t   update_tag,
    input  cache_pkg::data_t  update_data,
    input  logic              update_dirty
);
    import cache_pkg::*;

    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;
    tag_t                 tag_array  [num_lines];
    data_t                data_array [num_lines];

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            valid_bits <= '0;                                            // All lines empty.
        end
        else if (update)
        begin
            valid_bits[lookup_index] <= 1'b1;
        end
    end

    // Whole-line write, the line is a single word.
    always_ff @(posedge clk)
    begin
        if (update)
        begin
            dirty_bits[lookup_index] <= update_dirty;
            tag_array[lookup_index]  <= update_tag;
            data_array[lookup_index] <= update_data;
        end
    end

    assign line_valid = valid_bits[lookup_index];
    assign line_dirty = dirty_bits[lookup_index];
    assign line_tag   = tag_array[lookup_index];
    assign line_data  = data_array[lookup_index];

endmodule

`default_nettype wire

/* source/axi4lite_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module axi4lite_controller
(
    input  logic clk,
    input  logic reset,

    cache_mem_if.bus mem,

    input  logic arready,
    input  logic rvalid,
    input  logic awready,
    input  logic wready,
    input  logic bvalid,
    output logic arvalid,
    output logic rready,
    output logic awvalid,
    output logic wvalid,
    output logic bready
);

    typedef enum logic [2:0]
    {
        idle,
        read_handshake,
        read_wait,
        write_handshake,
        write_wait
    } axi_state_e;

    axi_state_e state, next_state;

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state    = state;
        mem.axi_ready = 1'b0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        awvalid       = 1'b0;
        wvalid        = 1'b0;
        bready        = 1'b0;

        case (state)
            idle:
            begin
                if (mem.axi_valid && !mem.mem_wr_req)
                begin
                    arvalid = 1'b1;                                      // Address out in this cycle.
                    rready  = 1'b1;
                    if (arready && rvalid)
                    begin
                        next_state    = idle;
                        mem.axi_ready = 1'b1;
                    end
                    else if (arready)
                        next_state = read_wait;
                    else
                        next_state = read_handshake;
                end
                else if (mem.axi_valid && mem.mem_wr_req)
                begin
                    awvalid = 1'b1;
                    wvalid  = 1'b1;
                    bready  = 1'b1;
                    if (awready && wready && bvalid)
                    begin
                        next_state    = idle;
                        mem.axi_ready = 1'b1;
                    end
                    else if (awready && wready)
                        next_state = write_wait;
                    else
                        next_state = write_handshake;
                end
            end

            read_handshake:
            begin
                arvalid = 1'b1;
                rready  = 1'b1;
                if (arready && rvalid)
                begin
                    next_state    = idle;
                    mem.axi_ready = 1'b1;
                end
                else if (arready)
                    next_state = read_wait;                              // Address taken, data pending.
            end

            read_wait:
            begin
                rready = 1'b1;
                if (rvalid)
                begin
                    next_state    = idle;
                    mem.axi_ready = 1'b1;
                end
            end

            write_handshake:
            begin
                awvalid = 1'b1;
                wvalid  = 1'b1;
                bready  = 1'b1;
                if (awready && wready && bvalid)
                begin
                    next_state    = idle;
                    mem.axi_ready = 1'b1;
                end
                else if (awready && wready)
                    next_state = write_wait;
            end

            write_wait:
            begin
                bready = 1'b1;                                           // Wait for the write response.
                if (bvalid)
                begin
                    next_state    = idle;
                    mem.axi_ready = 1'b1;
                end
            end

            default:
            begin
                next_state = idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/cache_mem_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cache_mem_if;
    import cache_pkg::*;

    logic  mem_wr_req;                                                   // High for a write-back.
    logic  axi_valid;
    logic  axi_ready;                                                    // One-cycle completion pulse.
    addr_t mem_addr;
    data_t mem_wdata;
    data_t mem_rdata;

    modport requester
    (
        output mem_wr_req, axi_valid, mem_addr, mem_wdata,
        input  axi_ready, mem_rdata
    );

    modport bus
    (
        input  mem_wr_req, axi_valid,
        output axi_ready
    );

    modport port
    (
        input  mem_addr, mem_wdata,
        output mem_rdata
    );

endinterface

`default_nettype wire

/* source/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int addr_width   = 32;
    localparam int data_width   = 32;
    localparam int index_width  = 4;
    localparam int offset_width = 2;                                     // Byte offset in a word.
    localparam int tag_width    = addr_width - index_width - offset_width;
    localparam int num_lines    = 2 ** index_width;

    typedef logic [addr_width-1:0]  addr_t;                              // Byte address.
    typedef logic [data_width-1:0]  data_t;
    typedef logic [index_width-1:0] index_t;                             // Address bits 5:2.
    typedef logic [tag_width-1:0]   tag_t;                               // Address bits 31:6.

    typedef enum logic [2:0]
    {
        idle,
        lookup,
        write_back,
        refill,
        respond
    } cache_state_e;

endpackage

`default_nettype wire
